//--- axi_ram.f
+incdir+rtl
rtl/axi_ram_pkg.sv
rtl/axi_if.sv
rtl/ram_if.sv
rtl/byte_lane_ram.sv
rtl/axi_ram_bridge.sv
rtl/axi_ram_top.sv
test/tb_clock.sv
test/tb_axi_ram.sv

//--- Makefile
TOP := tb_axi_ram

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f axi_ram.f

# the simulation output goes to the terminal and is searched for the pass line.
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir

//--- test/tb_axi_ram.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

module tb_axi_ram;

    typedef struct packed {
        logic                   is_write;
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;      // beats minus one.
        axi_ram_pkg::burst_t    burst;
        logic [`AXI_LANES-1:0]  strb;
        logic [31:0]            seed;
    } row_t;

    localparam int N_ROWS     = 11;
    localparam int MAX_CYCLES = 40 * N_ROWS + 100;

    logic clk;
    logic rst_n;
    logic [`AXI_ID_W-1:0]   ar_id, r_id, aw_id, b_id;
    logic [`AXI_ADDR_W-1:0] ar_addr, aw_addr;
    logic [`AXI_LEN_W-1:0]  ar_len, aw_len;
    logic [1:0]             ar_burst, aw_burst;
    logic [`AXI_DATA_W-1:0] r_data, w_data;
    logic [`AXI_LANES-1:0]  w_strb;
    logic ar_valid, ar_ready, r_last, r_valid, r_ready;
    logic aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;

    row_t                   rows [N_ROWS];
    logic [`AXI_DATA_W-1:0] ref_mem [`AXI_RAM_DEPTH];
    int                     n_checks;
    int                     n_errors;
    int                     cycles;

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    axi_ram_top i_dut (.*);

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic [`AXI_ADDR_W-1:0] next_addr(input logic [`AXI_ADDR_W-1:0] addr,
                                                         input axi_ram_pkg::burst_t burst);
        if (burst == axi_ram_pkg::INCR) begin
            return addr + 1; // wraps at the depth.
        end
        return addr;
    endfunction

    task automatic store_word(input logic [`AXI_ADDR_W-1:0] addr,
                              input logic [`AXI_DATA_W-1:0] data,
                              input logic [`AXI_LANES-1:0] strb);
        for (int i = 0; i < `AXI_LANES; i++) begin
            if (strb[i]) ref_mem[addr][8*i +: 8] = data[8*i +: 8];
        end
    endtask

    // ----------------------------------------
    // bursts
    // ----------------------------------------
    task automatic write_burst(input row_t row);
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] word;
        int unsigned            delay;
        addr = row.addr;
        @(posedge clk);
        aw_id    <= row.id;
        aw_addr  <= row.addr;
        aw_len   <= row.len;
        aw_burst <= row.burst;
        aw_valid <= 1'b1;
        @(negedge clk);
        while (!aw_ready) @(negedge clk);
        @(posedge clk);
        aw_valid <= 1'b0;
        for (int b = 0; b <= int'(row.len); b++) begin
            word = $urandom() ^ row.seed;
            w_data  <= word;
            w_strb  <= row.strb;
            w_last  <= (b == int'(row.len));
            w_valid <= 1'b1;
            @(negedge clk);
            while (!w_ready) @(negedge clk);
            @(posedge clk); // beat taken here.
            store_word(addr, word, row.strb);
            addr = next_addr(addr, row.burst);
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
        delay = $urandom_range(3);
        @(negedge clk);
        while (!b_valid) @(negedge clk);
        repeat (delay) begin
            @(negedge clk);
            check_value("b_valid", b_valid, 1); // must wait for bready.
        end
        check_value("b_id", b_id, row.id);
        @(posedge clk);
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        @(negedge clk);
        check_value("b_valid", b_valid, 0);
    endtask

    task automatic read_burst(input row_t row);
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] held;
        logic                   stalled;
        int                     beat;
        addr    = row.addr;
        beat    = 0;
        stalled = 1'b0;
        held    = '0;
        @(posedge clk);
        ar_id    <= row.id;
        ar_addr  <= row.addr;
        ar_len   <= row.len;
        ar_burst <= row.burst;
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
        r_ready  <= ($urandom_range(3) != 0);
        while (beat <= int'(row.len)) begin
            @(negedge clk);
            if (stalled) begin
                check_value("r_valid held", r_valid, 1);
                check_value("r_data held", r_data, held);
            end
            if (r_valid) begin
                check_value("r_data", r_data, ref_mem[addr]);
                check_value("r_id", r_id, row.id);
                check_value("r_last", r_last, beat == int'(row.len));
                stalled = !r_ready;
                held    = r_data;
                if (r_ready) begin
                    beat++;
                    addr = next_addr(addr, row.burst);
                end
            end
            @(posedge clk);
            r_ready <= ($urandom_range(3) != 0); // random stalls.
        end
        r_ready <= 1'b0;
        @(negedge clk);
        check_value("r_valid", r_valid, 0); // no extra beat.
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(65));
        n_checks = 0;
        n_errors = 0;
        ar_id    <= '0;
        ar_addr  <= '0;
        ar_len   <= '0;
        ar_burst <= '0;
        ar_valid <= 1'b0;
        aw_id    <= '0;
        aw_addr  <= '0;
        aw_len   <= '0;
        aw_burst <= '0;
        aw_valid <= 1'b0;
        w_data   <= '0;
        w_strb   <= '0;
        w_last   <= 1'b0;
        w_valid  <= 1'b0;
        r_ready  <= 1'b0;
        b_ready  <= 1'b0;

        // dir, id, addr, len, burst, strb, seed.
        rows[0]  = '{1'b1, 4'h3, 8'd16,  8'd3, axi_ram_pkg::INCR,  4'hf, 32'h0000_0000};
        rows[1]  = '{1'b0, 4'h5, 8'd16,  8'd3, axi_ram_pkg::INCR,  4'hf, 32'h0000_0000};
        rows[2]  = '{1'b1, 4'h1, 8'd17,  8'd1, axi_ram_pkg::INCR,  4'h5, 32'ha5a5_0000};
        rows[3]  = '{1'b1, 4'h2, 8'd18,  8'd0, axi_ram_pkg::INCR,  4'ha, 32'h0f0f_0f0f};
        rows[4]  = '{1'b0, 4'h6, 8'd16,  8'd3, axi_ram_pkg::INCR,  4'hf, 32'h0000_0000};
        rows[5]  = '{1'b1, 4'h7, 8'd40,  8'd3, axi_ram_pkg::FIXED, 4'hf, 32'h1234_5678};
        rows[6]  = '{1'b1, 4'h8, 8'd40,  8'd2, axi_ram_pkg::FIXED, 4'h3, 32'hffff_0000};
        rows[7]  = '{1'b0, 4'h9, 8'd40,  8'd3, axi_ram_pkg::FIXED, 4'hf, 32'h0000_0000};
        rows[8]  = '{1'b1, 4'ha, 8'd254, 8'd3, axi_ram_pkg::INCR,  4'hf, 32'hc3c3_c3c3};
        rows[9]  = '{1'b0, 4'hb, 8'd254, 8'd3, axi_ram_pkg::INCR,  4'hf, 32'h0000_0000};
        rows[10] = '{1'b0, 4'hc, 8'd0,   8'd1, axi_ram_pkg::INCR,  4'hf, 32'h0000_0000};

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("ar_ready", ar_ready, 1);
        check_value("aw_ready", aw_ready, 1);
        check_value("r_valid", r_valid, 0);
        check_value("r_last", r_last, 0);
        check_value("w_ready", w_ready, 0);
        check_value("b_valid", b_valid, 0);

        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].is_write) write_burst(rows[r]);
            else read_burst(rows[r]);
        end

        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // the run is bounded by the length of the table.
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the table did not finish within %0d cycles", MAX_CYCLES);
        $display("%0d checks, %0d errors", n_checks, n_errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 8 ns period.
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held over the first three rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- rtl/axi_ram_top.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

module axi_ram_top (
    input  logic                   clk,
    input  logic                   rst_n,
    // read address.
    input  logic [`AXI_ID_W-1:0]   ar_id,
    input  logic [`AXI_ADDR_W-1:0] ar_addr,
    input  logic [`AXI_LEN_W-1:0]  ar_len,
    input  logic [1:0]             ar_burst,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    // read data.
    output logic [`AXI_ID_W-1:0]   r_id,
    output logic [`AXI_DATA_W-1:0] r_data,
    output logic                   r_last,
    output logic                   r_valid,
    input  logic                   r_ready,
    // write address.
    input  logic [`AXI_ID_W-1:0]   aw_id,
    input  logic [`AXI_ADDR_W-1:0] aw_addr,
    input  logic [`AXI_LEN_W-1:0]  aw_len,
    input  logic [1:0]             aw_burst,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    // write data.
    input  logic [`AXI_DATA_W-1:0] w_data,
    input  logic [`AXI_LANES-1:0]  w_strb,
    input  logic                   w_last,
    input  logic                   w_valid,
    output logic                   w_ready,
    // write response.
    output logic [`AXI_ID_W-1:0]   b_id,
    output logic                   b_valid,
    input  logic                   b_ready
);

    axi_if axi_bus ();
    ram_if lane_bus [`AXI_LANES] ();

    // ----------------------------------------
    // pins onto the master side of the bus
    // ----------------------------------------
    assign axi_bus.ar_id    = ar_id;
    assign axi_bus.ar_addr  = ar_addr;
    assign axi_bus.ar_len   = ar_len;
    assign axi_bus.ar_burst = ar_burst;
    assign axi_bus.ar_valid = ar_valid;
    assign ar_ready         = axi_bus.ar_ready;

    assign r_id             = axi_bus.r_id;
    assign r_data           = axi_bus.r_data;
    assign r_last           = axi_bus.r_last;
    assign r_valid          = axi_bus.r_valid;
    assign axi_bus.r_ready  = r_ready;

    assign axi_bus.aw_id    = aw_id;
    assign axi_bus.aw_addr  = aw_addr;
    assign axi_bus.aw_len   = aw_len;
    assign axi_bus.aw_burst = aw_burst;
    assign axi_bus.aw_valid = aw_valid;
    assign aw_ready         = axi_bus.aw_ready;

    assign axi_bus.w_data   = w_data;
    assign axi_bus.w_strb   = w_strb;
    assign axi_bus.w_last   = w_last;
    assign axi_bus.w_valid  = w_valid;
    assign w_ready          = axi_bus.w_ready;

    assign b_id             = axi_bus.b_id;
    assign b_valid          = axi_bus.b_valid;
    assign axi_bus.b_ready  = b_ready;

    axi_ram_bridge i_bridge (
        .clk   (clk),
        .rst_n (rst_n),
        .axi   (axi_bus),
        .lanes (lane_bus)
    );

    // one ram per byte of the data word.
    for (genvar i = 0; i < `AXI_LANES; i++) begin : g_lane
        byte_lane_ram i_ram (
            .clk (clk),
            .mem (lane_bus[i])
        );
    end

endmodule

//--- rtl/axi_ram_bridge.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

module axi_ram_bridge (
    input logic  clk,
    input logic  rst_n,
    axi_if.slave axi,
    ram_if.ctrl  lanes [`AXI_LANES]
);

    // ----------------------------------------
    // read channel
    // ----------------------------------------
    axi_ram_pkg::rd_state_t rd_state;
    axi_ram_pkg::rd_state_t rd_state_nxt;
    axi_ram_pkg::burst_t    rd_burst;
    axi_ram_pkg::addr_t     rd_addr;
    axi_ram_pkg::addr_t     rd_addr_nxt;
    axi_ram_pkg::len_t      rd_len;       // beats left after the current one.
    logic [`AXI_ID_W-1:0]   rd_id;
    logic                   rd_valid;
    logic                   rd_step;
    logic                   rd_done;

    assign axi.ar_ready = (rd_state == axi_ram_pkg::rd_idle);
    assign axi.r_valid  = rd_valid;
    assign axi.r_last   = rd_valid && (rd_len == '0);
    assign axi.r_id     = rd_id;

    assign rd_step     = rd_valid && axi.r_ready;
    assign rd_done     = rd_step && (rd_len == '0);
    assign rd_addr_nxt = (rd_burst == axi_ram_pkg::INCR) ? rd_addr + 1'b1 : rd_addr;

    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            axi_ram_pkg::rd_idle: begin
                if (axi.ar_valid) begin
                    rd_state_nxt = axi_ram_pkg::rd_fetch;
                end
            end
            axi_ram_pkg::rd_fetch: rd_state_nxt = axi_ram_pkg::rd_resp;
            axi_ram_pkg::rd_resp: begin
                if (rd_done) begin
                    rd_state_nxt = axi_ram_pkg::rd_idle;
                end
            end
            default: rd_state_nxt = axi_ram_pkg::rd_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= axi_ram_pkg::rd_idle;
            rd_valid <= 1'b0;
            rd_burst <= axi_ram_pkg::FIXED;
            rd_addr  <= '0;
            rd_len   <= '0;
            rd_id    <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            // valid comes one cycle into rd_resp, once the first word has settled.
            rd_valid <= (rd_state == axi_ram_pkg::rd_resp) && !rd_done;
            if (axi.ar_valid && axi.ar_ready) begin
                rd_burst <= axi_ram_pkg::burst_t'(axi.ar_burst);
                rd_addr  <= axi.ar_addr;
                rd_len   <= axi.ar_len;
                rd_id    <= axi.ar_id;
            end else if (rd_step) begin
                rd_addr <= rd_addr_nxt;
                rd_len  <= rd_len - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // write channel
    // ----------------------------------------
    axi_ram_pkg::wr_state_t wr_state;
    axi_ram_pkg::wr_state_t wr_state_nxt;
    axi_ram_pkg::burst_t    wr_burst;
    axi_ram_pkg::addr_t     wr_addr;
    axi_ram_pkg::len_t      wr_len;
    logic [`AXI_ID_W-1:0]   wr_id;
    logic                   wr_beat;
    logic                   wr_end;

    assign axi.aw_ready = (wr_state == axi_ram_pkg::wr_idle);
    assign axi.w_ready  = (wr_state == axi_ram_pkg::wr_data);
    assign axi.b_valid  = (wr_state == axi_ram_pkg::wr_resp);
    assign axi.b_id     = wr_id;

    assign wr_beat = axi.w_valid && axi.w_ready;
    assign wr_end  = wr_beat && (axi.w_last || (wr_len == '0)); // whichever comes first.

    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            axi_ram_pkg::wr_idle: begin
                if (axi.aw_valid) begin
                    wr_state_nxt = axi_ram_pkg::wr_data;
                end
            end
            axi_ram_pkg::wr_data: begin
                if (wr_end) begin
                    wr_state_nxt = axi_ram_pkg::wr_resp;
                end
            end
            axi_ram_pkg::wr_resp: begin
                if (axi.b_ready) begin
                    wr_state_nxt = axi_ram_pkg::wr_idle;
                end
            end
            default: wr_state_nxt = axi_ram_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= axi_ram_pkg::wr_idle;
            wr_burst <= axi_ram_pkg::FIXED;
            wr_addr  <= '0;
            wr_len   <= '0;
            wr_id    <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            if (axi.aw_valid && axi.aw_ready) begin
                wr_burst <= axi_ram_pkg::burst_t'(axi.aw_burst);
                wr_addr  <= axi.aw_addr;
                wr_len   <= axi.aw_len;
                wr_id    <= axi.aw_id;
            end else if (wr_beat) begin
                if (wr_burst == axi_ram_pkg::INCR) begin
                    wr_addr <= wr_addr + 1'b1; // wraps at the top of memory.
                end
                wr_len <= wr_len - 1'b1;
            end
        end
    end

    // ----------------------------------------
    // byte lanes
    // ----------------------------------------
    for (genvar i = 0; i < `AXI_LANES; i++) begin : g_lane
        // look one word ahead when a beat is taken.
        assign lanes[i].rd_addr = rd_step ? rd_addr_nxt : rd_addr;
        assign axi.r_data[8*i +: 8] = lanes[i].rd_data;

        assign lanes[i].wr_addr = wr_addr;
        assign lanes[i].wr_data = axi.w_data[8*i +: 8];
        assign lanes[i].wr_en   = wr_beat && axi.w_strb[i];
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    // stalled beat must hold, including the data coming back from the rams.
    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axi.r_valid && !axi.r_ready |=> axi.r_valid && $stable(axi.r_data))
        else $error("read beat changed while stalled.");

endmodule

//--- rtl/byte_lane_ram.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

module byte_lane_ram (
    input logic clk,
    ram_if.mem  mem
);

    // ----------------------------------------
    // storage
    // ----------------------------------------
    logic [7:0] ram_q [`AXI_RAM_DEPTH];

    // one byte of every word in the memory.
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    // ----------------------------------------
    // registered read
    // ----------------------------------------
    // a read and a write to the same word on one edge
    // returns the old byte.
    always_ff @(posedge clk) begin
        mem.rd_data <= ram_q[mem.rd_addr];
    end

endmodule

//--- rtl/ram_if.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

interface ram_if;

    // read port, data follows the address by one edge.
    logic [`AXI_ADDR_W-1:0] rd_addr;
    logic [7:0]             rd_data;

    // write port.
    logic [`AXI_ADDR_W-1:0] wr_addr;
    logic [7:0]             wr_data;
    logic                   wr_en;

    modport ctrl (
        output rd_addr,
        input  rd_data,
        output wr_addr, wr_data, wr_en
    );

    modport mem (
        input  rd_addr,
        output rd_data,
        input  wr_addr, wr_data, wr_en
    );

endinterface

//--- rtl/axi_if.sv
`timescale 1ns/10ps
`include "axi_ram_cfg.svh"

interface axi_if;

    // read address.
    logic [`AXI_ID_W-1:0]   ar_id;
    logic [`AXI_ADDR_W-1:0] ar_addr;
    logic [`AXI_LEN_W-1:0]  ar_len;
    logic [1:0]             ar_burst;
    logic                   ar_valid;
    logic                   ar_ready;

    // read data.
    logic [`AXI_ID_W-1:0]   r_id;
    logic [`AXI_DATA_W-1:0] r_data;
    logic                   r_last;
    logic                   r_valid;
    logic                   r_ready;

    // write address.
    logic [`AXI_ID_W-1:0]   aw_id;
    logic [`AXI_ADDR_W-1:0] aw_addr;
    logic [`AXI_LEN_W-1:0]  aw_len;
    logic [1:0]             aw_burst;
    logic                   aw_valid;
    logic                   aw_ready;

    // write data.
    logic [`AXI_DATA_W-1:0] w_data;
    logic [`AXI_LANES-1:0]  w_strb;
    logic                   w_last;
    logic                   w_valid;
    logic                   w_ready;

    // write response, always okay.
    logic [`AXI_ID_W-1:0]   b_id;
    logic                   b_valid;
    logic                   b_ready;

    modport slave (
        input  ar_id, ar_addr, ar_len, ar_burst, ar_valid,
        output ar_ready,
        output r_id, r_data, r_last, r_valid,
        input  r_ready,
        input  aw_id, aw_addr, aw_len, aw_burst, aw_valid,
        output aw_ready,
        input  w_data, w_strb, w_last, w_valid,
        output w_ready,
        output b_id, b_valid,
        input  b_ready
    );

    modport master (
        output ar_id, ar_addr, ar_len, ar_burst, ar_valid,
        input  ar_ready,
        input  r_id, r_data, r_last, r_valid,
        output r_ready,
        output aw_id, aw_addr, aw_len, aw_burst, aw_valid,
        input  aw_ready,
        output w_data, w_strb, w_last, w_valid,
        input  w_ready,
        input  b_id, b_valid,
        output b_ready
    );

endinterface

//--- rtl/axi_ram_pkg.sv
`include "axi_ram_cfg.svh"

package axi_ram_pkg;

    // ----------------------------------------
    // burst encodings
    // ----------------------------------------
    // only the two supported AXI burst kinds.
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01
    } burst_t;

    // ----------------------------------------
    // channel state machines
    // ----------------------------------------
    typedef enum logic [1:0] {
        rd_idle  = 2'b00,
        rd_fetch = 2'b01,   // first word on its way out of the rams.
        rd_resp  = 2'b10
    } rd_state_t;

    typedef enum logic [1:0] {
        wr_idle = 2'b00,
        wr_data = 2'b01,
        wr_resp = 2'b10
    } wr_state_t;

    // latched request fields.
    typedef logic [`AXI_ADDR_W-1:0] addr_t;
    typedef logic [`AXI_LEN_W-1:0]  len_t;

endpackage

//--- rtl/axi_ram_cfg.svh
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define AXI_ID_W    4
`define AXI_ADDR_W  8               // word address.
`define AXI_DATA_W  32
`define AXI_LEN_W   8
`define AXI_LANES   (`AXI_DATA_W / 8) // also the strobe width.

// ----------------------------------------
// memory
// ----------------------------------------
`define AXI_RAM_DEPTH (1 << `AXI_ADDR_W) // words per lane.

`endif
